//--- source/arcade_config.svh
// Build constants for the arcade glue: download slots, DIP bank, video limits, palette
// Include wherever one of these numbers is needed

`ifndef ARCADE_CONFIG_SVH
`define ARCADE_CONFIG_SVH

// Download slots
`define ARC_GAME_INDEX      1
`define ARC_DIP_INDEX       254
`define ARC_DIP_BYTES       8
`define ARC_DIP_ADDR_BITS   3

// Game codes as sent by the loader
`define ARC_CODE_SPACEZAP   3
`define ARC_CODE_GORF       4
`define ARC_CODE_WOW        5
`define ARC_CODE_ROBBY      6
`define ARC_CODE_GORF1      7

// Interlace line fold
`define ARC_VFOLD_START     264
`define ARC_VFOLD_SUB       263

// Visible window edges, in folded lines and pixels
`define ARC_BLANK_TOP       21
`define ARC_BLANK_BOTTOM    260
`define ARC_BLANK_LEFT      70

// Stabilised vertical blank window
`define ARC_VBL_FIRST       25
`define ARC_VBL_LAST        254

// Space Zap monochrome grey levels
`define ARC_MONO_HI         238
`define ARC_MONO_MID        170
`define ARC_MONO_LO         136

// Audio mix clip level
`define ARC_AUDIO_SAT       65535

`endif

//--- source/arcade_pkg.sv
// Shared types for the arcade glue blocks
// Import into any block that decodes the game or the panel columns

package arcade_pkg;

	// ==============================
	// Selected game
	// ==============================

	// Dropped titles decode to GAME_NONE
	typedef enum logic [2:0] {
		GAME_NONE     = 3'd0,
		GAME_SPACEZAP = 3'd1,
		GAME_WOW      = 3'd2,
		GAME_GORF     = 3'd3,
		GAME_ROBBY    = 3'd4
	} game_t;

	// ==============================
	// Switch matrix columns
	// ==============================

	// One-hot strobes from the board
	// Column 3 is the DIP bank on all kept games
	typedef enum logic [7:0] {
		COL_0 = 8'h01,
		COL_1 = 8'h02,
		COL_2 = 8'h04,
		COL_3 = 8'h08
	} panel_col_t;

endpackage

//--- source/game_cfg_if.sv
// Game configuration bus from the download decoder to the game-dependent blocks
// Static levels, they move only after a download write

`timescale 1ns/1ps

interface game_cfg_if import arcade_pkg::*; ();

	// Decoded title
	game_t      game;
	// Gorf Program 1 ROM set
	logic       gorf_program1;

	// DIP bytes read by the blocks
	logic [7:0] dip0;
	logic [7:0] dip2;
	logic [7:0] dip3;

	// Written by the decoder
	modport cfg_src (output game, gorf_program1, dip0, dip2, dip3);

	// Read by panel, video and audio
	modport cfg_dst (input game, gorf_program1, dip0, dip2, dip3);

endinterface

//--- source/game_select.sv
// Latches the game code and the DIP bank from loader writes
// Game is valid two edges after the write, a DIP byte one edge after

`timescale 1ns/1ps

`include "arcade_config.svh"

module game_select import arcade_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        dl_wr,
	input  logic [7:0]  dl_index,
	input  logic [24:0] dl_addr,
	input  logic [7:0]  dl_data,
	game_cfg_if.cfg_src cfg
);

	logic [7:0] code_q;
	logic [7:0] dip_bank [`ARC_DIP_BYTES];
	game_t      game_q;
	logic       gorf1_q;
	logic       game_wr;
	logic       dip_wr;

	// ==============================
	// Write decode
	// ==============================

	assign game_wr = dl_wr && (dl_index == 8'(`ARC_GAME_INDEX));
	// Only the first eight bytes of the slot hold switches
	assign dip_wr  = dl_wr && (dl_index == 8'(`ARC_DIP_INDEX))
		&& (dl_addr[24:`ARC_DIP_ADDR_BITS] == '0);

	// Raw code from the loader
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			code_q <= 8'd0;
		end else if (game_wr) begin
			code_q <= dl_data;
		end
	end

	// Switch bank, all open after reset
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < `ARC_DIP_BYTES; i++) begin
				dip_bank[i] <= 8'hff;
			end
		end else if (dip_wr) begin
			dip_bank[dl_addr[`ARC_DIP_ADDR_BITS-1:0]] <= dl_data;
		end
	end

	// ==============================
	// Code to game map
	// ==============================

	// Second stage, so game lags the code by one edge
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			game_q  <= GAME_NONE;
			gorf1_q <= 1'b0;
		end else begin
			case (code_q)
				8'(`ARC_CODE_SPACEZAP): game_q <= GAME_SPACEZAP;
				8'(`ARC_CODE_GORF):     game_q <= GAME_GORF;
				8'(`ARC_CODE_WOW):      game_q <= GAME_WOW;
				8'(`ARC_CODE_ROBBY):    game_q <= GAME_ROBBY;
				// Program 1 runs on the Gorf board
				8'(`ARC_CODE_GORF1):    game_q <= GAME_GORF;
				default:                game_q <= GAME_NONE;
			endcase
			// Holds while the stored code stays 7
			gorf1_q <= (code_q == 8'(`ARC_CODE_GORF1));
		end
	end

	assign cfg.game          = game_q;
	assign cfg.gorf_program1 = gorf1_q;
	assign cfg.dip0          = dip_bank[0];
	assign cfg.dip2          = dip_bank[2];
	assign cfg.dip3          = dip_bank[3];

endmodule

//--- source/control_panel.sv
// Switch matrix for the kept games, returns the row byte of the strobed column
// Pure logic, the board samples row_data in the same cycle

`timescale 1ns/1ps

module control_panel import arcade_pkg::*; (
	game_cfg_if.cfg_dst cfg,
	input  logic [7:0]  col_select,
	input  logic        p1_up,
	input  logic        p1_down,
	input  logic        p1_left,
	input  logic        p1_right,
	input  logic        p1_fire,
	input  logic        p1_fire2,
	input  logic        p2_up,
	input  logic        p2_down,
	input  logic        p2_left,
	input  logic        p2_right,
	input  logic        p2_fire,
	input  logic        p2_fire2,
	input  logic        start1,
	input  logic        start2,
	input  logic        coin,
	input  logic        speech_busy,
	output logic [7:0]  row_data
);

	// Board reads switches active low
	logic [3:0] p1_dir_n;
	logic [3:0] p2_dir_n;
	logic [7:0] col0_sz, col1_sz, col2_sz;
	logic [7:0] col0_wow, col1_wow, col2_wow;
	logic [7:0] col0_gorf, col1_gorf, col2_gorf;
	logic [7:0] col0_robby, col1_robby, col2_robby;

	// Order right, left, down, up on the low nibble
	assign p1_dir_n = ~{p1_right, p1_left, p1_down, p1_up};
	assign p2_dir_n = ~{p2_right, p2_left, p2_down, p2_up};

	// ==============================
	// Space Zap
	// ==============================

	assign col0_sz = {2'b11, ~start2, ~start1, cfg.dip2[1], 1'b1, ~coin, 1'b1};
	assign col1_sz = {3'b111, ~p2_fire, p2_dir_n};
	// dip2 bit 0 sits in the player 1 column
	assign col2_sz = {2'b11, cfg.dip2[0], ~p1_fire, p1_dir_n};

	// ==============================
	// Wizard of Wor
	// ==============================

	assign col0_wow = {cfg.dip2[2], ~start2, ~start1, 1'b1, cfg.dip2[1], 1'b1, ~coin, 1'b1};
	// Move button is active high on digital controls
	assign col1_wow = {2'b11, ~p2_fire, p2_fire2, p2_dir_n};
	assign col2_wow = {speech_busy, 1'b1, ~p1_fire, p1_fire2, p1_dir_n};

	// ==============================
	// Gorf and Robby Roto
	// ==============================

	assign col0_gorf = {cfg.dip2[2], cfg.dip2[0], ~start2, ~start1, 1'b1,
		cfg.dip2[1], ~coin, 1'b1};
	assign col1_gorf = {3'b001, ~p2_fire, p2_dir_n};
	// Speech busy flag on bit 7
	assign col2_gorf = {speech_busy, 2'b01, ~p1_fire, p1_dir_n};

	assign col0_robby = {1'b0, ~start2, ~start1, 1'b1, cfg.dip2[1], 1'b1, ~coin, 1'b1};
	assign col1_robby = {2'b11, ~p2_fire, 1'b1, p2_dir_n};
	assign col2_robby = {2'b11, ~p1_fire, 1'b1, p1_dir_n};

	// Column and game select
	always_comb begin
		row_data = 8'hff;
		case (col_select)
			COL_0: begin
				case (cfg.game)
					GAME_SPACEZAP: row_data = col0_sz;
					GAME_WOW:      row_data = col0_wow;
					GAME_GORF:     row_data = col0_gorf;
					GAME_ROBBY:    row_data = col0_robby;
					default:       row_data = 8'hff;
				endcase
			end
			COL_1: begin
				case (cfg.game)
					GAME_SPACEZAP: row_data = col1_sz;
					GAME_WOW:      row_data = col1_wow;
					GAME_GORF:     row_data = col1_gorf;
					GAME_ROBBY:    row_data = col1_robby;
					default:       row_data = 8'hff;
				endcase
			end
			COL_2: begin
				case (cfg.game)
					GAME_SPACEZAP: row_data = col2_sz;
					GAME_WOW:      row_data = col2_wow;
					GAME_GORF:     row_data = col2_gorf;
					GAME_ROBBY:    row_data = col2_robby;
					default:       row_data = 8'hff;
				endcase
			end
			// DIP bank on every game
			COL_3: row_data = cfg.dip3;
			default: row_data = 8'hff;
		endcase
	end

endmodule

//--- source/video_post.sv
// Colour output stage: line fold, edge blanking, stable vblank, Space Zap mono
// One register stage, a new pixel every clock

`timescale 1ns/1ps

`include "arcade_config.svh"

module video_post import arcade_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	game_cfg_if.cfg_dst cfg,
	input  logic [3:0]  board_r,
	input  logic [3:0]  board_g,
	input  logic [3:0]  board_b,
	input  logic [8:0]  hcount,
	input  logic [10:0] vcount,
	output logic [7:0]  video_r,
	output logic [7:0]  video_g,
	output logic [7:0]  video_b,
	output logic        vblank
);

	logic [10:0] line_fold;
	logic        edge_blank;
	logic        mono_on;
	logic        vbl_next;
	logic [7:0]  r_next;
	logic [7:0]  g_next;
	logic [7:0]  b_next;

	// ==============================
	// Line fold and windows
	// ==============================

	// Second field maps back onto the first
	assign line_fold = (vcount >= 11'(`ARC_VFOLD_START)) ?
		vcount - 11'(`ARC_VFOLD_SUB) : vcount;

	assign edge_blank = (line_fold >= 11'(`ARC_BLANK_BOTTOM))
		|| (line_fold <= 11'(`ARC_BLANK_TOP))
		|| (hcount <= 9'(`ARC_BLANK_LEFT));

	// Board blank jitters, rebuild it from the folded line
	assign vbl_next = (line_fold < 11'(`ARC_VBL_FIRST))
		|| (line_fold > 11'(`ARC_VBL_LAST));

	// Mono switch on DIP 0 bit 1
	assign mono_on = (cfg.game == GAME_SPACEZAP) && cfg.dip0[1];

	// ==============================
	// Colour path
	// ==============================

	always_comb begin
		// 4 bit to 8 bit by repeating the nibble
		r_next = {board_r, board_r};
		g_next = {board_g, board_g};
		b_next = {board_b, board_b};
		if (mono_on) begin
			// Later match wins
			if ((board_g == 4'd15) && (board_b == 4'd4)) begin
				r_next = 8'(`ARC_MONO_HI);
				g_next = 8'(`ARC_MONO_HI);
				b_next = 8'(`ARC_MONO_HI);
			end
			if (board_b == 4'd11) begin
				r_next = 8'(`ARC_MONO_MID);
				g_next = 8'(`ARC_MONO_MID);
				b_next = 8'(`ARC_MONO_MID);
			end
			if (board_g == 4'd4) begin
				r_next = 8'(`ARC_MONO_LO);
				g_next = 8'(`ARC_MONO_LO);
				b_next = 8'(`ARC_MONO_LO);
			end
		end
		// Edges go black whatever the game
		if (edge_blank) begin
			r_next = 8'd0;
			g_next = 8'd0;
			b_next = 8'd0;
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			video_r <= 8'd0;
			video_g <= 8'd0;
			video_b <= 8'd0;
			vblank  <= 1'b0;
		end else begin
			video_r <= r_next;
			video_g <= g_next;
			video_b <= b_next;
			vblank  <= vbl_next;
		end
	end

endmodule

//--- source/audio_mix.sv
// Sound chip and speech mixer with clipping, one register stage
// Gorf and Wizard of Wor add speech, the rest play the chip only

`timescale 1ns/1ps

`include "arcade_config.svh"

module audio_mix import arcade_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	game_cfg_if.cfg_dst cfg,
	input  logic [7:0]  chip_l,
	input  logic [7:0]  chip_r,
	input  logic [15:0] sample_l,
	input  logic [15:0] sample_r,
	output logic [15:0] audio_l,
	output logic [15:0] audio_r
);

	// Chip scaled just below full range, speech halved
	function automatic logic [15:0] mix_sat(input logic [7:0] chip, input logic [15:0] sample);
		logic [16:0] work;
		work = {1'b0, chip, chip[7:1]} + {2'b00, sample[15:1]};
		// Carry out means past full scale
		return work[16] ? 16'(`ARC_AUDIO_SAT) : work[15:0];
	endfunction

	logic speech_game;

	assign speech_game = (cfg.game == GAME_GORF) || (cfg.game == GAME_WOW);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			audio_l <= 16'd0;
			audio_r <= 16'd0;
		end else if (speech_game) begin
			audio_l <= mix_sat(chip_l, sample_l);
			audio_r <= mix_sat(chip_r, sample_r);
		end else if (cfg.game == GAME_ROBBY) begin
			// Two chips, true stereo
			audio_l <= {chip_l, chip_l};
			audio_r <= {chip_r, chip_r};
		end else begin
			// Single chip on both speakers
			audio_l <= {chip_l, chip_l};
			audio_r <= {chip_l, chip_l};
		end
	end

endmodule

//--- source/arcade_glue_top.sv
// Top of the arcade glue, plain ports toward the board and the host
// Connects the config bus to the panel, video and audio blocks

`timescale 1ns/1ps

module arcade_glue_top (
	input  logic        clk_sys,
	input  logic        reset,
	// Loader
	input  logic        dl_wr,
	input  logic [7:0]  dl_index,
	input  logic [24:0] dl_addr,
	input  logic [7:0]  dl_data,
	// Players
	input  logic        p1_up, p1_down, p1_left, p1_right, p1_fire, p1_fire2,
	input  logic        p2_up, p2_down, p2_left, p2_right, p2_fire, p2_fire2,
	input  logic        start1, start2, coin,
	// From the board
	input  logic [7:0]  col_select,
	input  logic        speech_busy,
	input  logic [3:0]  board_r, board_g, board_b,
	input  logic [8:0]  hcount,
	input  logic [10:0] vcount,
	input  logic [7:0]  chip_l, chip_r,
	input  logic [15:0] sample_l, sample_r,
	// To the board and the outside
	output logic [7:0]  row_data,
	output logic        gorf_program1,
	output logic [7:0]  video_r, video_g, video_b,
	output logic        vblank,
	output logic [15:0] audio_l, audio_r
);

	game_cfg_if cfg_bus ();

	// Board ROM select
	assign gorf_program1 = cfg_bus.gorf_program1;

	game_select i_game_select (
		.clk_sys(clk_sys), .reset(reset), .dl_wr(dl_wr), .dl_index(dl_index),
		.dl_addr(dl_addr), .dl_data(dl_data), .cfg(cfg_bus.cfg_src)
	);

	control_panel i_control_panel (
		.cfg(cfg_bus.cfg_dst), .col_select(col_select),
		.p1_up(p1_up), .p1_down(p1_down), .p1_left(p1_left), .p1_right(p1_right),
		.p1_fire(p1_fire), .p1_fire2(p1_fire2),
		.p2_up(p2_up), .p2_down(p2_down), .p2_left(p2_left), .p2_right(p2_right),
		.p2_fire(p2_fire), .p2_fire2(p2_fire2),
		.start1(start1), .start2(start2), .coin(coin), .speech_busy(speech_busy),
		.row_data(row_data)
	);

	video_post i_video_post (
		.clk_sys(clk_sys), .reset(reset), .cfg(cfg_bus.cfg_dst),
		.board_r(board_r), .board_g(board_g), .board_b(board_b),
		.hcount(hcount), .vcount(vcount),
		.video_r(video_r), .video_g(video_g), .video_b(video_b), .vblank(vblank)
	);

	audio_mix i_audio_mix (
		.clk_sys(clk_sys), .reset(reset), .cfg(cfg_bus.cfg_dst),
		.chip_l(chip_l), .chip_r(chip_r), .sample_l(sample_l), .sample_r(sample_r),
		.audio_l(audio_l), .audio_r(audio_r)
	);

endmodule

//--- verif/tb_arcade_glue.sv
// Testbench for the arcade glue top, random panel, video and audio stimulus
// Concurrent assertions compare against models of the game rules

`timescale 1ns/1ps

`include "arcade_config.svh"

module tb_arcade_glue import arcade_pkg::*;;

	localparam int CLK_PERIOD   = 10;
	localparam int RESET_CYCLES = 16;
	localparam int LOAD_CYCLES  = 3;
	localparam int SHORT_RUN    = 64;
	localparam int LONG_RUN     = 300;
	localparam int MONO_CYCLES  = 4;
	// Sum of all test lengths, see the test sequence below
	localparam int TEST_CYCLES  = RESET_CYCLES + 6 + 13 * LOAD_CYCLES + 13 * SHORT_RUN
		+ LONG_RUN + MONO_CYCLES;
	localparam int MARGIN       = 200;

	logic        clk_sys, reset, dl_wr;
	logic [7:0]  dl_index, dl_data, col_select;
	logic [24:0] dl_addr;
	logic        p1_up, p1_down, p1_left, p1_right, p1_fire, p1_fire2;
	logic        p2_up, p2_down, p2_left, p2_right, p2_fire, p2_fire2;
	logic        start1, start2, coin, speech_busy;
	logic [3:0]  board_r, board_g, board_b;
	logic [8:0]  hcount;
	logic [10:0] vcount;
	logic [7:0]  chip_l, chip_r;
	logic [15:0] sample_l, sample_r;
	logic [7:0]  row_data, video_r, video_g, video_b;
	logic        gorf_program1, vblank;
	logic [15:0] audio_l, audio_r;

	// Model state, moved by the tests once the DUT has settled
	game_t       exp_game;
	logic        exp_gp1;
	logic [7:0]  exp_dip0, exp_dip3;
	logic        chk_on;
	logic [31:0] lfsr;
	int          errors;
	int          tests_done;

	logic [3:0]  p1n, p2n;
	logic [7:0]  exp_row, exp_r, exp_g, exp_b;
	logic        row_chk, exp_vbl;
	logic [15:0] exp_al, exp_ar;
	logic [24:0] exp_vid_q;
	logic [31:0] exp_aud_q;
	int          fold;

	arcade_glue_top i_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// ==============================
	// Models
	// ==============================

	// Switch matrix, only columns with a known layout are checked
	always_comb begin
		p1n = ~{p1_right, p1_left, p1_down, p1_up};
		p2n = ~{p2_right, p2_left, p2_down, p2_up};
		row_chk = 1'b1;
		exp_row = 8'hff;
		if (col_select == COL_3)
			exp_row = exp_dip3;
		else if (!(col_select inside {COL_0, COL_1, COL_2}) || exp_game == GAME_NONE)
			exp_row = 8'hff;
		else if (col_select == COL_1 && exp_game == GAME_SPACEZAP)
			exp_row = {3'b111, ~p2_fire, p2n};
		else if (col_select == COL_1 && exp_game == GAME_GORF)
			exp_row = {3'b001, ~p2_fire, p2n};
		else if (col_select == COL_2 && exp_game == GAME_GORF)
			exp_row = {speech_busy, 2'b01, ~p1_fire, p1n};
		else if (col_select == COL_2 && exp_game == GAME_ROBBY)
			exp_row = {2'b11, ~p1_fire, 1'b1, p1n};
		else if (col_select == COL_1 && exp_game == GAME_WOW)
			exp_row = {2'b11, ~p2_fire, p2_fire2, p2n};
		else
			row_chk = 1'b0;
	end

	// Video rules on the folded line
	always_comb begin
		fold = (int'(vcount) >= `ARC_VFOLD_START) ? int'(vcount) - `ARC_VFOLD_SUB : int'(vcount);
		exp_r = 8'(board_r * 17);
		exp_g = 8'(board_g * 17);
		exp_b = 8'(board_b * 17);
		if (exp_game == GAME_SPACEZAP && exp_dip0[1]) begin
			if (board_g == 4'd15 && board_b == 4'd4)
				{exp_r, exp_g, exp_b} = {3{8'(`ARC_MONO_HI)}};
			if (board_b == 4'd11)
				{exp_r, exp_g, exp_b} = {3{8'(`ARC_MONO_MID)}};
			if (board_g == 4'd4)
				{exp_r, exp_g, exp_b} = {3{8'(`ARC_MONO_LO)}};
		end
		if (fold >= `ARC_BLANK_BOTTOM || fold <= `ARC_BLANK_TOP || hcount <= `ARC_BLANK_LEFT)
			{exp_r, exp_g, exp_b} = 24'd0;
		exp_vbl = (fold < `ARC_VBL_FIRST) || (fold > `ARC_VBL_LAST);
	end

	// Chip scaled by 128.5 plus half the speech, clipped
	function automatic logic [15:0] mix_model(input int chip, input int sample);
		int s;
		s = chip * 128 + chip / 2 + sample / 2;
		return (s > 65535) ? 16'hffff : 16'(s);
	endfunction

	always_comb begin
		if (exp_game == GAME_GORF || exp_game == GAME_WOW) begin
			exp_al = mix_model(chip_l, sample_l);
			exp_ar = mix_model(chip_r, sample_r);
		end else if (exp_game == GAME_ROBBY) begin
			exp_al = 16'(chip_l * 257);
			exp_ar = 16'(chip_r * 257);
		end else begin
			exp_al = 16'(chip_l * 257);
			exp_ar = 16'(chip_l * 257);
		end
	end

	// One stage of model delay for the registered outputs, cleared like the DUT
	always @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			exp_vid_q <= '0;
			exp_aud_q <= '0;
		end else begin
			exp_vid_q <= {exp_r, exp_g, exp_b, exp_vbl};
			exp_aud_q <= {exp_al, exp_ar};
		end
	end

	// ==============================
	// Checks
	// ==============================

	task automatic report_mismatch(input string what, input logic [31:0] got,
		input logic [31:0] want);
		$display("mismatch at %0t: %s is %h, expected %h", $time, what, got, want);
		errors++;
	endtask

	task automatic expect_now(input string what, input logic [31:0] got,
		input logic [31:0] want);
		assert (got === want) else report_mismatch(what, got, want);
	endtask

	assert property (@(posedge clk_sys) disable iff (reset || !chk_on)
		!row_chk || row_data == exp_row)
		else report_mismatch("row_data", $sampled(row_data), $sampled(exp_row));

	assert property (@(posedge clk_sys) disable iff (reset || !chk_on)
		gorf_program1 == exp_gp1)
		else report_mismatch("gorf_program1", $sampled(gorf_program1), $sampled(exp_gp1));

	assert property (@(posedge clk_sys) disable iff (reset || !chk_on)
		{video_r, video_g, video_b, vblank} == exp_vid_q)
		else report_mismatch("video rgb and vblank",
			$sampled({video_r, video_g, video_b, vblank}), $sampled(exp_vid_q));

	assert property (@(posedge clk_sys) disable iff (reset || !chk_on)
		{audio_l, audio_r} == exp_aud_q)
		else report_mismatch("audio", $sampled({audio_l, audio_r}), $sampled(exp_aud_q));

	// ==============================
	// Stimulus
	// ==============================

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Big mode pushes chip and speech near full scale
	task automatic drive_random(input bit big);
		{p1_up, p1_down, p1_left, p1_right, p1_fire, p1_fire2} = 6'(next_bits(6));
		{p2_up, p2_down, p2_left, p2_right, p2_fire, p2_fire2} = 6'(next_bits(6));
		{start1, start2, coin, speech_busy} = 4'(next_bits(4));
		case (next_bits(3))
			0: col_select = COL_0;
			1: col_select = COL_1;
			2: col_select = COL_2;
			3: col_select = COL_3;
			4: col_select = 8'h00;
			default: col_select = 8'h30;
		endcase
		board_r = 4'(next_bits(4));
		board_g = 4'(next_bits(4));
		board_b = 4'(next_bits(4));
		hcount = 9'(next_bits(9));
		// Two fields plus some lines past the end
		vcount = 11'(next_bits(10));
		chip_l = big ? (8'hf0 | 8'(next_bits(4))) : 8'(next_bits(8));
		chip_r = big ? (8'hf0 | 8'(next_bits(4))) : 8'(next_bits(8));
		sample_l = big ? (16'hff00 | 16'(next_bits(8))) : 16'(next_bits(16));
		sample_r = big ? (16'hff00 | 16'(next_bits(8))) : 16'(next_bits(16));
	endtask

	task automatic run_cycles(input int n, input bit big);
		repeat (n) begin
			@(posedge clk_sys);
			#1;
			drive_random(big);
		end
	endtask

	// Visible pixels hitting each grey level, the last one matches two rules
	task automatic drive_mono_pixels();
		for (int i = 0; i < MONO_CYCLES; i++) begin
			@(posedge clk_sys);
			#1;
			hcount = 9'd100;
			vcount = 11'd100;
			board_r = 4'd3;
			case (i)
				0: {board_g, board_b} = {4'd15, 4'd4};
				1: {board_g, board_b} = {4'd7, 4'd11};
				2: {board_g, board_b} = {4'd4, 4'd2};
				default: {board_g, board_b} = {4'd4, 4'd11};
			endcase
		end
	endtask

	// Game valid two edges after the write, checks resume one edge later
	task automatic load_game(input logic [7:0] code, input game_t game, input logic gp1);
		chk_on = 1'b0;
		dl_wr = 1'b1;
		dl_index = 8'(`ARC_GAME_INDEX);
		dl_data = code;
		@(posedge clk_sys);
		#1;
		dl_wr = 1'b0;
		@(posedge clk_sys);
		#1;
		exp_game = game;
		exp_gp1 = gp1;
		expect_now("gorf_program1 after load", gorf_program1, gp1);
		@(posedge clk_sys);
		#1;
		chk_on = 1'b1;
	endtask

	// DIP byte readable on the next cycle
	task automatic write_dip(input logic [2:0] addr, input logic [7:0] value);
		chk_on = 1'b0;
		dl_wr = 1'b1;
		dl_index = 8'(`ARC_DIP_INDEX);
		dl_addr = 25'(addr);
		dl_data = value;
		@(posedge clk_sys);
		#1;
		dl_wr = 1'b0;
		if (addr == 3'd0)
			exp_dip0 = value;
		if (addr == 3'd3)
			exp_dip3 = value;
		col_select = COL_3;
		#1;
		expect_now("row_data on COL_3 after DIP write", row_data, exp_dip3);
		@(posedge clk_sys);
		#1;
		chk_on = 1'b1;
	endtask

	task automatic finish_test(input string name);
		tests_done++;
		$display("test %0d (%s) finished, errors so far %0d", tests_done, name, errors);
	endtask

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		lfsr = 32'h1067a77f;
		errors = 0;
		tests_done = 0;
		chk_on = 1'b0;
		exp_game = GAME_NONE;
		exp_gp1 = 1'b0;
		exp_dip0 = 8'hff;
		exp_dip3 = 8'hff;
		reset = 1'b1;
		{dl_wr, dl_index, dl_addr, dl_data, col_select, speech_busy} = '0;
		{p1_up, p1_down, p1_left, p1_right, p1_fire, p1_fire2} = '0;
		{p2_up, p2_down, p2_left, p2_right, p2_fire, p2_fire2} = '0;
		{start1, start2, coin, board_r, board_g, board_b, hcount, vcount} = '0;
		{chip_l, chip_r, sample_l, sample_r} = '0;

		// Outputs held in their reset state
		repeat (RESET_CYCLES - 1) @(posedge clk_sys);
		#1;
		for (int c = 0; c < 5; c++) begin
			col_select = (c == 4) ? 8'h40 : 8'(1 << c);
			#1;
			expect_now("row_data in reset", row_data, 8'hff);
		end
		expect_now("gorf_program1 in reset", gorf_program1, 1'b0);
		expect_now("video in reset", {video_r, video_g, video_b, vblank}, 25'd0);
		expect_now("audio in reset", {audio_l, audio_r}, 32'd0);
		@(posedge clk_sys);
		#1;
		reset = 1'b0;
		chk_on = 1'b1;
		finish_test("after reset");

		load_game(8'(`ARC_CODE_SPACEZAP), GAME_SPACEZAP, 1'b0);
		run_cycles(SHORT_RUN, 1'b0);
		load_game(8'(`ARC_CODE_GORF), GAME_GORF, 1'b0);
		run_cycles(SHORT_RUN, 1'b0);
		load_game(8'(`ARC_CODE_ROBBY), GAME_ROBBY, 1'b0);
		run_cycles(SHORT_RUN, 1'b0);
		load_game(8'(`ARC_CODE_WOW), GAME_WOW, 1'b0);
		run_cycles(SHORT_RUN, 1'b0);
		finish_test("game selection");

		load_game(8'(`ARC_CODE_GORF1), GAME_GORF, 1'b1);
		run_cycles(SHORT_RUN, 1'b0);
		load_game(8'(`ARC_CODE_SPACEZAP), GAME_SPACEZAP, 1'b0);
		run_cycles(SHORT_RUN, 1'b0);
		finish_test("gorf program 1");

		write_dip(3'd3, 8'(next_bits(8)));
		write_dip(3'd0, 8'h00);
		load_game(8'(`ARC_CODE_SPACEZAP), GAME_SPACEZAP, 1'b0);
		run_cycles(SHORT_RUN, 1'b0);
		write_dip(3'd0, 8'h02);
		run_cycles(SHORT_RUN, 1'b0);
		finish_test("dip bank");

		// Mono palette stays on from the last DIP write
		load_game(8'(`ARC_CODE_SPACEZAP), GAME_SPACEZAP, 1'b0);
		drive_mono_pixels();
		run_cycles(LONG_RUN, 1'b0);
		load_game(8'(`ARC_CODE_WOW), GAME_WOW, 1'b0);
		run_cycles(SHORT_RUN, 1'b0);
		finish_test("video");

		load_game(8'(`ARC_CODE_GORF), GAME_GORF, 1'b0);
		run_cycles(SHORT_RUN, 1'b1);
		load_game(8'(`ARC_CODE_WOW), GAME_WOW, 1'b0);
		run_cycles(SHORT_RUN, 1'b1);
		load_game(8'(`ARC_CODE_ROBBY), GAME_ROBBY, 1'b0);
		run_cycles(SHORT_RUN, 1'b0);
		// Dropped title code
		load_game(8'd2, GAME_NONE, 1'b0);
		run_cycles(SHORT_RUN, 1'b0);
		finish_test("audio");

		$display("tests run %0d, errors %0d", tests_done, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// Watchdog
	initial begin
		#((TEST_CYCLES + MARGIN) * CLK_PERIOD);
		$display("Watchdog expired before the tests completed");
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- all.f
+incdir+source
source/arcade_pkg.sv
source/game_cfg_if.sv
source/game_select.sv
source/control_panel.sv
source/video_post.sv
source/audio_mix.sv
source/arcade_glue_top.sv
verif/tb_arcade_glue.sv
